// File: Makefile
# Verilator build and run of the host TLP bridge testbench

VERILATOR ?= verilator
TOP       ?= host_tlp_map_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors
FAIL_MSG  ?= Done: errors found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/host_tlp_map_tb.sv
// Random host and AFU traffic against an AXI4-Lite slave model
// Expected TLPs and MMIO accesses come from a queue model in the bench
// Slave memory is 256 words, indexed by address bits 9:2
// Reset is active while reset_n is high

`timescale 1ns/1ps
`default_nettype none

module host_tlp_map_tb import pcie_tlp_pkg::*; ();

    localparam int N_HOST = 300;
    localparam int N_AFU = 120;
    localparam int CLK_PERIOD = 20;

    logic clk;
    logic reset_n;
    logic rx_valid;
    logic rx_ready;
    t_tlp_hdr rx_hdr;
    t_tlp_data rx_data;
    logic tx_valid;
    logic tx_ready;
    t_tlp_hdr tx_hdr;
    t_tlp_data tx_data;
    logic m_axil_awvalid;
    logic m_axil_awready;
    t_tlp_addr m_axil_awaddr;
    logic m_axil_wvalid;
    logic m_axil_wready;
    t_tlp_data m_axil_wdata;
    logic m_axil_bvalid;
    logic m_axil_bready;
    logic m_axil_arvalid;
    logic m_axil_arready;
    t_tlp_addr m_axil_araddr;
    logic m_axil_rvalid;
    logic m_axil_rready;
    t_tlp_data m_axil_rdata;
    logic afu_wr_valid;
    logic afu_wr_ready;
    t_tlp_addr afu_wr_addr;
    t_tlp_data afu_wr_data;
    t_req_id req_id;

    integer seed = 87598;
    int err_value = 0;
    int err_other = 0;
    int n_conflict = 0;
    logic cpl_due = 1'b0;

    // Reference memory follows host issue order, slave memory follows the bus
    t_tlp_data model_mem [256];
    t_tlp_data slave_mem [256];

    // Expected traffic, oldest first
    t_tlp_addr exp_wr_addr [$];
    t_tlp_data exp_wr_data [$];
    t_tlp_addr exp_rd_addr [$];
    t_tlp_hdr exp_cpl_hdr [$];
    t_tlp_data exp_cpl_data [$];
    t_tlp_hdr exp_afu_hdr [$];
    t_tlp_data exp_afu_data [$];

    host_tlp_map i_host_tlp_map (.*);

    // ====================
    // Helpers
    // ====================
    function automatic int rand_below(input int n);
        rand_below = {$random(seed)} % n;
    endfunction

    // Every bit of the word index shows up in the pattern
    function automatic t_tlp_data fill_word(input int idx);
        logic [7:0] i;
        i = idx[7:0];
        fill_word = {8'h5a ^ i, ~i, i, 8'hc3 ^ i};
    endfunction

    // Lands 2 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_hdr(input string name, input t_tlp_hdr exp, input t_tlp_hdr act);
        if (act !== exp)
        begin
            err_value++;
            $display("Fail %s at %0t: expected %h, actual %h", name, $time, exp, act);
        end
    endtask

    task automatic check_data(input string name, input t_tlp_data exp, input t_tlp_data act);
        if (act !== exp)
        begin
            err_value++;
            $display("Fail %s at %0t: expected %h, actual %h", name, $time, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input t_tlp_addr exp, input t_tlp_addr act);
        if (act !== exp)
        begin
            err_value++;
            $display("Fail %s at %0t: expected %h, actual %h", name, $time, exp, act);
        end
    endtask

    // ====================
    // Host RX traffic
    // ====================
    task automatic host_traffic();
        int k;
        int kind;
        t_tlp_hdr hdr;
        t_tlp_hdr cpl;
        t_tlp_data data;
        t_tlp_addr axi_addr;
        for (k = 0; k < N_HOST; k++)
        begin
            // 0..3 supported, 4 bad length, 5 and 6 unsupported types
            kind = rand_below(7);
            hdr.length = 10'd1;
            hdr.requester_id = t_req_id'($random(seed));
            hdr.tag = t_tlp_tag'($random(seed));
            hdr.addr = {$random(seed), $random(seed)};
            data = $random(seed);
            case (kind)
                0: hdr.fmttype = MRD32;
                1: hdr.fmttype = MRD64;
                2: hdr.fmttype = MWR32;
                3: hdr.fmttype = MWR64;
                4:
                begin
                    hdr.fmttype = (rand_below(2) == 0) ? MRD64 : MWR32;
                    hdr.length = t_tlp_len'(2 + rand_below(8));
                end
                5: hdr.fmttype = CPLD;
                default: hdr.fmttype = t_fmttype'(8'h04);
            endcase
            // Upper bits of a 32-bit form are garbage on the wire
            axi_addr = (kind == 0 || kind == 2) ? {32'b0, hdr.addr[31:0]} : hdr.addr;
            if (kind == 2 || kind == 3)
            begin
                exp_wr_addr.push_back(axi_addr);
                exp_wr_data.push_back(data);
                model_mem[axi_addr[9:2]] = data;
            end
            else if (kind < 2)
            begin
                cpl = '0;
                cpl.fmttype = CPLD;
                cpl.length = 10'd1;
                cpl.requester_id = hdr.requester_id;
                cpl.tag = hdr.tag;
                cpl.addr = t_tlp_addr'(hdr.addr[6:0]);
                exp_rd_addr.push_back(axi_addr);
                exp_cpl_hdr.push_back(cpl);
                exp_cpl_data.push_back(model_mem[axi_addr[9:2]]);
            end
            rx_hdr = hdr;
            rx_data = data;
            rx_valid = 1'b1;
            do @(negedge clk); while (!rx_ready);
            wait_cycles(1);
            rx_valid = 1'b0;
            wait_cycles(rand_below(3));
        end
    endtask

    // ====================
    // AFU posted writes
    // ====================
    task automatic afu_traffic();
        int k;
        logic short_addr;
        t_tlp_hdr hdr;
        t_tlp_addr addr;
        t_tlp_data data;
        for (k = 0; k < N_AFU; k++)
        begin
            addr = {$random(seed), $random(seed)};
            short_addr = (rand_below(2) == 0);
            // Long addresses keep the top bit set so they never fit in 32 bits
            if (short_addr)
                addr[63:32] = '0;
            else
                addr[63] = 1'b1;
            data = $random(seed);
            hdr = '0;
            // 3DW header only when the address fits in 32 bits
            hdr.fmttype = short_addr ? MWR32 : MWR64;
            hdr.length = 10'd1;
            hdr.requester_id = req_id;
            hdr.addr = addr;
            exp_afu_hdr.push_back(hdr);
            exp_afu_data.push_back(data);
            afu_wr_addr = addr;
            afu_wr_data = data;
            afu_wr_valid = 1'b1;
            do @(negedge clk); while (!afu_wr_ready);
            wait_cycles(1);
            afu_wr_valid = 1'b0;
            wait_cycles(rand_below(4));
        end
    endtask

    // ====================
    // TX checks
    // ====================
    task automatic check_tx_beat();
        t_tlp_hdr h;
        t_tlp_data d;
        if (tx_hdr.fmttype == CPLD && exp_cpl_hdr.size() == 0)
        begin
            err_other++;
            $display("Unexpected completion on TX at %0t, header %h", $time, tx_hdr);
        end
        else if (tx_hdr.fmttype == CPLD)
        begin
            h = exp_cpl_hdr.pop_front();
            d = exp_cpl_data.pop_front();
            check_hdr("completion header", h, tx_hdr);
            check_data("completion data", d, tx_data);
        end
        else if (exp_afu_hdr.size() == 0)
        begin
            err_other++;
            $display("Unexpected write TLP on TX at %0t, header %h", $time, tx_hdr);
        end
        else
        begin
            h = exp_afu_hdr.pop_front();
            d = exp_afu_data.pop_front();
            check_hdr("afu write header", h, tx_hdr);
            check_data("afu write data", d, tx_data);
        end
    endtask

    always @(negedge clk)
    begin
        // Both sources waiting at a free output, the completion must load next
        if (cpl_due && (!tx_valid || tx_hdr.fmttype != CPLD))
        begin
            err_other++;
            $display("AFU write went ahead of a waiting completion at %0t", $time);
        end
        cpl_due = !reset_n && (!tx_valid || tx_ready) &&
                  i_host_tlp_map.cpl_tlp.valid && i_host_tlp_map.afu_tlp.valid;
        if (cpl_due)
            n_conflict++;
        if (!reset_n && tx_valid && tx_ready)
            check_tx_beat();
    end

    // ====================
    // AXI4-Lite slave model
    // ====================
    initial
    begin
        t_tlp_addr a;
        t_tlp_data d;
        forever
        begin
            @(negedge clk);
            if (!reset_n && m_axil_awvalid)
            begin
                wait_cycles(1 + rand_below(4));
                m_axil_awready = 1'b1;
                m_axil_wready = 1'b1;
                @(negedge clk);
                if (!m_axil_wvalid)
                begin
                    err_other++;
                    $display("AXI wvalid low while awvalid waits at %0t", $time);
                end
                if (exp_wr_addr.size() == 0)
                begin
                    err_other++;
                    $display("Unexpected AXI write to %h at %0t", m_axil_awaddr, $time);
                end
                else
                begin
                    a = exp_wr_addr.pop_front();
                    d = exp_wr_data.pop_front();
                    check_addr("axi write address", a, m_axil_awaddr);
                    check_data("axi write data", d, m_axil_wdata);
                end
                slave_mem[m_axil_awaddr[9:2]] = m_axil_wdata;
                wait_cycles(1);
                m_axil_awready = 1'b0;
                m_axil_wready = 1'b0;
                wait_cycles(rand_below(4));
                m_axil_bvalid = 1'b1;
                do @(negedge clk); while (!m_axil_bready);
                wait_cycles(1);
                m_axil_bvalid = 1'b0;
            end
        end
    end

    initial
    begin
        t_tlp_addr a;
        forever
        begin
            @(negedge clk);
            if (!reset_n && m_axil_arvalid)
            begin
                wait_cycles(1 + rand_below(4));
                m_axil_arready = 1'b1;
                @(negedge clk);
                a = m_axil_araddr;
                if (exp_rd_addr.size() == 0)
                begin
                    err_other++;
                    $display("Unexpected AXI read from %h at %0t", a, $time);
                end
                else
                    check_addr("axi read address", exp_rd_addr.pop_front(), a);
                wait_cycles(1);
                m_axil_arready = 1'b0;
                wait_cycles(rand_below(5));
                m_axil_rdata = slave_mem[a[9:2]];
                m_axil_rvalid = 1'b1;
                do @(negedge clk); while (!m_axil_rready);
                wait_cycles(1);
                m_axil_rvalid = 1'b0;
            end
        end
    end

    // ====================
    // Clock, back-pressure, watchdog
    // ====================
    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        forever
        begin
            @(posedge clk);
            #2;
            tx_ready = (rand_below(4) != 0);
        end
    end

    initial
    begin
        repeat ((N_HOST + N_AFU) * 200) @(posedge clk);
        $display("Timeout: traffic did not drain in %0d cycles", (N_HOST + N_AFU) * 200);
        $display("Done: errors found");
        $finish;
    end

    // ====================
    // Main sequence
    // ====================
    initial
    begin
        int i;
        reset_n = 1'b1;
        rx_valid = 1'b0;
        rx_hdr = '0;
        rx_data = '0;
        tx_ready = 1'b0;
        m_axil_awready = 1'b0;
        m_axil_wready = 1'b0;
        m_axil_bvalid = 1'b0;
        m_axil_arready = 1'b0;
        m_axil_rvalid = 1'b0;
        m_axil_rdata = '0;
        afu_wr_valid = 1'b0;
        afu_wr_addr = '0;
        afu_wr_data = '0;
        req_id = t_req_id'($random(seed));
        for (i = 0; i < 256; i++)
        begin
            model_mem[i] = fill_word(i);
            slave_mem[i] = fill_word(i);
        end
        wait_cycles(4);
        reset_n = 1'b0;
        fork
            host_traffic();
            afu_traffic();
        join
        while (exp_wr_addr.size() != 0 || exp_rd_addr.size() != 0 ||
               exp_cpl_hdr.size() != 0 || exp_afu_hdr.size() != 0)
            wait_cycles(1);
        // Idle tail so stray TLPs or bus cycles still show up
        wait_cycles(30);
        $display("Errors: %0d value mismatches, %0d other failures, %0d arbitration conflicts",
                 err_value, err_other, n_conflict);
        if (err_value + err_other == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/afu_wr_tlp_gen.sv
// AFU posted write to MWr TLP
// Single DW, tag zero, requester id from the top level
// 3DW header when the address fits in 32 bits

`timescale 1ns/1ps
`default_nettype none

module afu_wr_tlp_gen import pcie_tlp_pkg::*;
(
    input  logic clk,
    input  logic reset_n,

    input  logic afu_wr_valid,
    output logic afu_wr_ready,
    input  t_tlp_addr afu_wr_addr,
    input  t_tlp_data afu_wr_data,
    input  t_req_id req_id,

    tlp_stream_if.source tx
);

    logic addr_is_32;

    assign addr_is_32 = (afu_wr_addr[63:32] == 32'b0);

    assign afu_wr_ready = !tx.valid || tx.ready;

    always_ff @(posedge clk)
    begin
        if (reset_n)
            tx.valid <= 1'b0;
        else if (afu_wr_ready)
            tx.valid <= afu_wr_valid;
    end

    always_ff @(posedge clk)
    begin
        if (afu_wr_valid && afu_wr_ready)
        begin
            tx.hdr.fmttype <= addr_is_32 ? MWR32 : MWR64;
            tx.hdr.length <= t_tlp_len'(1);
            tx.hdr.requester_id <= req_id;
            // Posted, so the tag is never matched
            tx.hdr.tag <= '0;
            tx.hdr.addr <= afu_wr_addr;
            tx.data <= afu_wr_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/host_tlp_config.svh
// Fixed widths for the host TLP to MMIO bridge
// Single-DW payloads only, so data width is one PCIe DW
// Lower address width matches the CplD lower address field

`ifndef HOST_TLP_CONFIG_SVH
`define HOST_TLP_CONFIG_SVH

// Host address, always carried as a 64-bit value
`define HTM_ADDR_W 64

// MMIO and TLP payload width
`define HTM_DATA_W 32

// PCIe tag width
`define HTM_TAG_W 8

// Completion lower address field
`define HTM_LOWER_ADDR_W 7

`endif

// File: verilog/host_tlp_map.sv
// Host TLP stream to AXI4-Lite MMIO bridge, top level
// Single-DW requests only, one MMIO transaction at a time
// Completions take priority over AFU writes on TX

`timescale 1ns/1ps
`default_nettype none

module host_tlp_map import pcie_tlp_pkg::*, mmio_pkg::*;
(
    input  logic clk,
    input  logic reset_n,

    // Host RX TLPs
    input  logic rx_valid,
    output logic rx_ready,
    input  t_tlp_hdr rx_hdr,
    input  t_tlp_data rx_data,

    // Host TX TLPs
    output logic tx_valid,
    input  logic tx_ready,
    output t_tlp_hdr tx_hdr,
    output t_tlp_data tx_data,

    // AFU MMIO port
    output logic m_axil_awvalid,
    input  logic m_axil_awready,
    output t_tlp_addr m_axil_awaddr,
    output logic m_axil_wvalid,
    input  logic m_axil_wready,
    output t_tlp_data m_axil_wdata,
    input  logic m_axil_bvalid,
    output logic m_axil_bready,
    output logic m_axil_arvalid,
    input  logic m_axil_arready,
    output t_tlp_addr m_axil_araddr,
    input  logic m_axil_rvalid,
    output logic m_axil_rready,
    input  t_tlp_data m_axil_rdata,

    // AFU posted writes
    input  logic afu_wr_valid,
    output logic afu_wr_ready,
    input  t_tlp_addr afu_wr_addr,
    input  t_tlp_data afu_wr_data,
    input  t_req_id req_id
);

    mmio_req_if mmio_req ();
    tlp_stream_if cpl_tlp ();
    tlp_stream_if afu_tlp ();

    // Read completion link, master to CplD builder
    logic cpl_valid;
    logic cpl_ready;
    t_cpl_meta cpl_meta;
    t_tlp_data cpl_data;

    // ====================
    // Host to MMIO
    // ====================
    tlp_rx_decode i_tlp_rx_decode (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_hdr   (rx_hdr),
        .rx_data  (rx_data),
        .req      (mmio_req.source)
    );

    mmio_axil_master i_mmio_axil_master (
        .clk            (clk),
        .reset_n        (reset_n),
        .req            (mmio_req.sink),
        .m_axil_awvalid (m_axil_awvalid),
        .m_axil_awready (m_axil_awready),
        .m_axil_awaddr  (m_axil_awaddr),
        .m_axil_wvalid  (m_axil_wvalid),
        .m_axil_wready  (m_axil_wready),
        .m_axil_wdata   (m_axil_wdata),
        .m_axil_bvalid  (m_axil_bvalid),
        .m_axil_bready  (m_axil_bready),
        .m_axil_arvalid (m_axil_arvalid),
        .m_axil_arready (m_axil_arready),
        .m_axil_araddr  (m_axil_araddr),
        .m_axil_rvalid  (m_axil_rvalid),
        .m_axil_rready  (m_axil_rready),
        .m_axil_rdata   (m_axil_rdata),
        .cpl_valid      (cpl_valid),
        .cpl_ready      (cpl_ready),
        .cpl_meta       (cpl_meta),
        .cpl_data       (cpl_data)
    );

    // ====================
    // TX sources and merge
    // ====================
    mmio_cpl_gen i_mmio_cpl_gen (
        .clk       (clk),
        .reset_n   (reset_n),
        .cpl_valid (cpl_valid),
        .cpl_ready (cpl_ready),
        .cpl_meta  (cpl_meta),
        .cpl_data  (cpl_data),
        .tx        (cpl_tlp.source)
    );

    afu_wr_tlp_gen i_afu_wr_tlp_gen (
        .clk          (clk),
        .reset_n      (reset_n),
        .afu_wr_valid (afu_wr_valid),
        .afu_wr_ready (afu_wr_ready),
        .afu_wr_addr  (afu_wr_addr),
        .afu_wr_data  (afu_wr_data),
        .req_id       (req_id),
        .tx           (afu_tlp.source)
    );

    // Completions on the high-priority side
    tlp_tx_arb i_tlp_tx_arb (
        .clk      (clk),
        .reset_n  (reset_n),
        .hi       (cpl_tlp.sink),
        .lo       (afu_tlp.sink),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_hdr   (tx_hdr),
        .tx_data  (tx_data)
    );

endmodule

`default_nettype wire

// File: verilog/mmio_axil_master.sv
// AXI4-Lite master for decoded host requests
// One transaction in flight, request ready only in IDLE
// Read data returns as one completion with the saved metadata

`timescale 1ns/1ps
`default_nettype none

module mmio_axil_master import pcie_tlp_pkg::*, mmio_pkg::*;
(
    input  logic clk,
    input  logic reset_n,

    mmio_req_if.sink req,

    // Write address and data
    output logic m_axil_awvalid,
    input  logic m_axil_awready,
    output t_tlp_addr m_axil_awaddr,
    output logic m_axil_wvalid,
    input  logic m_axil_wready,
    output t_tlp_data m_axil_wdata,

    // Write response
    input  logic m_axil_bvalid,
    output logic m_axil_bready,

    // Read address and data
    output logic m_axil_arvalid,
    input  logic m_axil_arready,
    output t_tlp_addr m_axil_araddr,
    input  logic m_axil_rvalid,
    output logic m_axil_rready,
    input  t_tlp_data m_axil_rdata,

    // Read completions
    output logic cpl_valid,
    input  logic cpl_ready,
    output t_cpl_meta cpl_meta,
    output t_tlp_data cpl_data
);

    t_axil_state state;
    t_tlp_addr addr_q;
    t_tlp_data wdata_q;
    logic aw_done;
    logic w_done;

    assign req.ready = (state == IDLE);

    // Channel finished once its valid is low or handshaking now
    assign aw_done = !m_axil_awvalid || m_axil_awready;
    assign w_done = !m_axil_wvalid || m_axil_wready;

    assign m_axil_awaddr = addr_q;
    assign m_axil_araddr = addr_q;
    assign m_axil_wdata = wdata_q;

    // ====================
    // Transaction FSM
    // ====================
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state <= IDLE;
            m_axil_awvalid <= 1'b0;
            m_axil_wvalid <= 1'b0;
            m_axil_bready <= 1'b0;
            m_axil_arvalid <= 1'b0;
            m_axil_rready <= 1'b0;
            cpl_valid <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (req.valid && req.req.is_write)
                    begin
                        // AW and W start together
                        m_axil_awvalid <= 1'b1;
                        m_axil_wvalid <= 1'b1;
                        state <= WR_ADDR_DATA;
                    end
                    else if (req.valid)
                    begin
                        m_axil_arvalid <= 1'b1;
                        state <= RD_ADDR;
                    end
                end
                WR_ADDR_DATA:
                begin
                    // Each channel drops on its own handshake
                    if (m_axil_awready)
                        m_axil_awvalid <= 1'b0;
                    if (m_axil_wready)
                        m_axil_wvalid <= 1'b0;
                    if (aw_done && w_done)
                    begin
                        m_axil_bready <= 1'b1;
                        state <= WR_RESP;
                    end
                end
                WR_RESP:
                begin
                    if (m_axil_bvalid)
                    begin
                        m_axil_bready <= 1'b0;
                        state <= IDLE;
                    end
                end
                RD_ADDR:
                begin
                    if (m_axil_arready)
                    begin
                        m_axil_arvalid <= 1'b0;
                        m_axil_rready <= 1'b1;
                        state <= RD_DATA;
                    end
                end
                RD_DATA:
                begin
                    // First the R beat, then hold the completion until taken
                    if (m_axil_rready && m_axil_rvalid)
                    begin
                        m_axil_rready <= 1'b0;
                        cpl_valid <= 1'b1;
                    end
                    else if (cpl_valid && cpl_ready)
                    begin
                        cpl_valid <= 1'b0;
                        state <= IDLE;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Request fields and read data
    always_ff @(posedge clk)
    begin
        if (req.valid && req.ready)
        begin
            addr_q <= req.req.addr;
            wdata_q <= req.req.data;
            cpl_meta.requester_id <= req.req.requester_id;
            cpl_meta.tag <= req.req.tag;
            cpl_meta.lower_addr <= t_lower_addr'(req.req.addr);
        end
        if (m_axil_rready && m_axil_rvalid)
            cpl_data <= m_axil_rdata;
    end

    a_aw_in_state: assert property (@(posedge clk) disable iff (reset_n)
        m_axil_awvalid |-> state == WR_ADDR_DATA);

    a_ar_stable: assert property (@(posedge clk) disable iff (reset_n)
        m_axil_arvalid && !m_axil_arready |=> $stable(m_axil_araddr));

endmodule

`default_nettype wire

// File: verilog/mmio_cpl_gen.sv
// CplD builder for MMIO read data
// Always one DW, successful status, byte count 4

`timescale 1ns/1ps
`default_nettype none

module mmio_cpl_gen import pcie_tlp_pkg::*, mmio_pkg::*;
(
    input  logic clk,
    input  logic reset_n,

    input  logic cpl_valid,
    output logic cpl_ready,
    input  t_cpl_meta cpl_meta,
    input  t_tlp_data cpl_data,

    tlp_stream_if.source tx
);

    // Register empty or draining
    assign cpl_ready = !tx.valid || tx.ready;

    always_ff @(posedge clk)
    begin
        if (reset_n)
            tx.valid <= 1'b0;
        else if (cpl_ready)
            tx.valid <= cpl_valid;
    end

    always_ff @(posedge clk)
    begin
        if (cpl_valid && cpl_ready)
        begin
            tx.hdr.fmttype <= CPLD;
            tx.hdr.length <= t_tlp_len'(1);
            tx.hdr.requester_id <= cpl_meta.requester_id;
            tx.hdr.tag <= cpl_meta.tag;
            // Lower address zero extended into addr
            tx.hdr.addr <= t_tlp_addr'(cpl_meta.lower_addr);
            tx.data <= cpl_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mmio_pkg.sv
// MMIO side types of the bridge
// One outstanding request at a time, so no tag tracking table

`default_nettype none

`include "host_tlp_config.svh"

package mmio_pkg;

    import pcie_tlp_pkg::*;

    typedef logic [`HTM_LOWER_ADDR_W-1:0] t_lower_addr;

    // Decoded host memory request
    typedef struct packed {
        logic is_write;
        t_tlp_addr addr;
        t_tlp_data data;
        t_req_id requester_id;
        t_tlp_tag tag;
    } t_mmio_req;

    // What a CplD needs from the original read
    typedef struct packed {
        t_req_id requester_id;
        t_tlp_tag tag;
        t_lower_addr lower_addr;
    } t_cpl_meta;

    typedef enum logic [2:0] {
        IDLE,
        WR_ADDR_DATA,
        WR_RESP,
        RD_ADDR,
        RD_DATA
    } t_axil_state;

endpackage

`default_nettype wire

// File: verilog/pcie_tlp_pkg.sv
// PCIe TLP field types for the single-DW bridge
// Header struct is a flattened view and not the wire format of a TLP
// Completions reuse addr for the lower address and imply byte count 4

`default_nettype none

`include "host_tlp_config.svh"

package pcie_tlp_pkg;

    typedef logic [`HTM_ADDR_W-1:0] t_tlp_addr;
    typedef logic [`HTM_DATA_W-1:0] t_tlp_data;
    typedef logic [`HTM_TAG_W-1:0] t_tlp_tag;
    typedef logic [15:0] t_req_id;

    // Length in DW, as in the TLP header
    typedef logic [9:0] t_tlp_len;

    // Standard fmt[2:0] and type[4:0] codes
    typedef enum logic [7:0] {
        MRD32 = 8'h00,
        MRD64 = 8'h20,
        MWR32 = 8'h40,
        MWR64 = 8'h60,
        CPLD  = 8'h4a
    } t_fmttype;

    typedef struct packed {
        t_fmttype fmttype;
        t_tlp_len length;
        t_req_id requester_id;
        t_tlp_tag tag;
        // Low 7 bits hold the lower address in a CplD
        t_tlp_addr addr;
    } t_tlp_hdr;

endpackage

`default_nettype wire

// File: verilog/tlp_ifs.sv
// Valid/ready links between bridge stages
// A beat moves when valid and ready are both high
// Source holds valid and payload until the beat moves

`timescale 1ns/1ps
`default_nettype none

// One TLP per beat, header plus a single DW
interface tlp_stream_if import pcie_tlp_pkg::*; ();

    logic valid;
    logic ready;
    t_tlp_hdr hdr;
    t_tlp_data data;

    modport source (output valid, output hdr, output data, input ready);
    modport sink (input valid, input hdr, input data, output ready);

endinterface

// Decoded MMIO request, decode stage to AXI master
interface mmio_req_if import mmio_pkg::*; ();

    logic valid;
    logic ready;
    t_mmio_req req;

    modport source (output valid, output req, input ready);
    modport sink (input valid, input req, output ready);

endinterface

`default_nettype wire

// File: verilog/tlp_rx_decode.sv
// Host RX TLP decode, one TLP per beat
// Only single-DW MRd and MWr pass, anything else is consumed and dropped
// One-entry output register, no skid buffer

`timescale 1ns/1ps
`default_nettype none

module tlp_rx_decode import pcie_tlp_pkg::*, mmio_pkg::*;
(
    input  logic clk,
    input  logic reset_n,

    input  logic rx_valid,
    output logic rx_ready,
    input  t_tlp_hdr rx_hdr,
    input  t_tlp_data rx_data,

    mmio_req_if.source req
);

    logic supported;
    logic is_addr32;

    // Memory request of exactly one DW
    assign supported = (rx_hdr.fmttype inside {MRD32, MRD64, MWR32, MWR64}) &&
                       (rx_hdr.length == t_tlp_len'(1));
    assign is_addr32 = (rx_hdr.fmttype == MRD32) || (rx_hdr.fmttype == MWR32);

    // Stage empty or being drained
    assign rx_ready = !req.valid || req.ready;

    // Control
    always_ff @(posedge clk)
    begin
        if (reset_n)
            req.valid <= 1'b0;
        else if (rx_ready)
            // Dropped beats leave the stage empty
            req.valid <= rx_valid && supported;
    end

    // Payload
    always_ff @(posedge clk)
    begin
        if (rx_valid && rx_ready && supported)
        begin
            req.req.is_write <= (rx_hdr.fmttype == MWR32) || (rx_hdr.fmttype == MWR64);
            // 32-bit forms carry no upper address
            req.req.addr <= is_addr32 ? {32'b0, rx_hdr.addr[31:0]} : rx_hdr.addr;
            req.req.data <= rx_data;
            req.req.requester_id <= rx_hdr.requester_id;
            req.req.tag <= rx_hdr.tag;
        end
    end

    // Request held until the master takes it
    a_req_hold: assert property (@(posedge clk) disable iff (reset_n)
        req.valid && !req.ready |=> req.valid);

endmodule

`default_nettype wire

// File: verilog/tlp_tx_arb.sv
// Fixed-priority TX merge, hi input always wins
// Lo input can starve under steady completion traffic
// Registered output, loaded when empty or draining

`timescale 1ns/1ps
`default_nettype none

module tlp_tx_arb import pcie_tlp_pkg::*;
(
    input  logic clk,
    input  logic reset_n,

    tlp_stream_if.sink hi,
    tlp_stream_if.sink lo,

    output logic tx_valid,
    input  logic tx_ready,
    output t_tlp_hdr tx_hdr,
    output t_tlp_data tx_data
);

    logic out_free;

    assign out_free = !tx_valid || tx_ready;

    // Lo waits whenever hi has a beat
    assign hi.ready = out_free;
    assign lo.ready = out_free && !hi.valid;

    always_ff @(posedge clk)
    begin
        if (reset_n)
            tx_valid <= 1'b0;
        else if (out_free)
            tx_valid <= hi.valid || lo.valid;
    end

    always_ff @(posedge clk)
    begin
        if (out_free)
        begin
            tx_hdr <= hi.valid ? hi.hdr : lo.hdr;
            tx_data <= hi.valid ? hi.data : lo.data;
        end
    end

    a_tx_stable: assert property (@(posedge clk) disable iff (reset_n)
        tx_valid && !tx_ready |=> $stable(tx_hdr));

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verilog
verilog/pcie_tlp_pkg.sv
verilog/mmio_pkg.sv
verilog/tlp_ifs.sv
verilog/tlp_rx_decode.sv
verilog/mmio_axil_master.sv
verilog/mmio_cpl_gen.sv
verilog/afu_wr_tlp_gen.sv
verilog/tlp_tx_arb.sv
verilog/host_tlp_map.sv
bench/host_tlp_map_tb.sv
